//--- verilog/io_bus_pkg.sv
// Bus-level definitions for the peripheral I/O subsystem.
// Covers the request bus widths and types, the region map seen by the
// address decoder and the state encoding of the bridge FSM.
// Other files refer to these by package scope with no import.

package io_bus_pkg;

   // ****************************************
   // Widths and types
   // ****************************************

   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;

   typedef logic [ADDR_W-1:0]   addr_t;
   typedef logic [DATA_W-1:0]   data_t;
   typedef logic [DATA_W/8-1:0] strb_t;

   // ****************************************
   // Region map
   // ****************************************

   // Upper address byte picks the region
   localparam addr_t REGION_MASK = 16'hFF00;

   localparam addr_t SYS_BASE  = 16'h0000;
   localparam addr_t GPIO_BASE = 16'h0100;

   // Read data returned with err for anything outside the map
   localparam data_t UNMAPPED_DATA = 32'hDEAD_BEEF;

   // Bridge FSM states
   typedef enum logic [1:0] {
      IDLE,
      BUS,
      RESP
   } bridge_state_t;

endpackage

//--- verilog/periph_pkg.sv
// Peripheral register map and widths.
// Holds the register offsets inside each region and the pin and counter
// widths used by the timer and GPIO blocks.

package periph_pkg;

   // Offset within a region
   localparam int REG_OFS_W = 8;

   typedef logic [REG_OFS_W-1:0] reg_ofs_t;

   // ****************************************
   // System timer registers
   // ****************************************

   // Bit 0 is the enable
   localparam reg_ofs_t TMR_CTRL  = 8'h00;
   localparam reg_ofs_t TMR_COUNT = 8'h04;
   localparam reg_ofs_t TMR_CMP   = 8'h08;

   typedef logic [31:0] tmr_t;

   // ****************************************
   // GPIO registers
   // ****************************************

   localparam reg_ofs_t GPIO_OUT = 8'h00;
   localparam reg_ofs_t GPIO_OE  = 8'h04;
   // Read only
   localparam reg_ofs_t GPIO_IN  = 8'h08;

   localparam int GPIO_W = 32;

   typedef logic [GPIO_W-1:0] gpio_t;

endpackage

//--- verilog/bus_bridge_fsm.sv
// Request/response bridge onto the internal register bus.
// Accepts one valid/ready request at a time, runs a single strobed bus
// cycle and holds the result on the response channel until it is taken.
// Read data is forced to zero in responses to writes.

`timescale 1ns/100ps

module bus_bridge_fsm (
   input  logic               clk,
   input  logic               i_arst_n,
   input  logic               i_req_valid,
   input  logic               i_req_we,
   input  io_bus_pkg::addr_t  i_req_addr,
   input  io_bus_pkg::data_t  i_req_wdata,
   input  io_bus_pkg::strb_t  i_req_strb,
   output logic               o_req_ready,
   output logic               o_rsp_valid,
   output io_bus_pkg::data_t  o_rsp_rdata,
   output logic               o_rsp_err,
   input  logic               i_rsp_ready,
   output logic               o_bus_stb,
   output logic               o_bus_we,
   output io_bus_pkg::addr_t  o_bus_addr,
   output io_bus_pkg::data_t  o_bus_wdata,
   output io_bus_pkg::strb_t  o_bus_strb,
   input  logic               i_bus_ack,
   input  logic               i_bus_err,
   input  io_bus_pkg::data_t  i_bus_rdata
);

   io_bus_pkg::bridge_state_t state;

   logic req_acc;
   logic bus_done;
   logic rsp_done;

   assign o_req_ready = (state == io_bus_pkg::IDLE);
   assign o_rsp_valid = (state == io_bus_pkg::RESP);

   assign req_acc  = i_req_valid & o_req_ready;
   assign bus_done = (state == io_bus_pkg::BUS) & i_bus_ack;
   assign rsp_done = o_rsp_valid & i_rsp_ready;

   // ****************************************
   // State and strobe
   // ****************************************

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state     <= io_bus_pkg::IDLE;
         o_bus_stb <= 1'b0;
      end else begin
         // One-cycle strobe on the accepting edge
         o_bus_stb <= req_acc;
         case (state)
            io_bus_pkg::IDLE: if (req_acc)  state <= io_bus_pkg::BUS;
            io_bus_pkg::BUS:  if (bus_done) state <= io_bus_pkg::RESP;
            io_bus_pkg::RESP: if (rsp_done) state <= io_bus_pkg::IDLE;
            default:                        state <= io_bus_pkg::IDLE;
         endcase
      end
   end

   // Request fields held for the whole bus cycle
   always_ff @(posedge clk) begin
      if (req_acc) begin
         o_bus_we    <= i_req_we;
         o_bus_addr  <= i_req_addr;
         o_bus_wdata <= i_req_wdata;
         o_bus_strb  <= i_req_strb;
      end
   end

   // Response captured on ack and held until taken
   always_ff @(posedge clk) begin
      if (bus_done) begin
         o_rsp_rdata <= o_bus_we ? '0 : i_bus_rdata;
         o_rsp_err   <= i_bus_err;
      end
   end

endmodule

//--- verilog/periph_decode.sv
// Address decoder for the internal register bus.
// Steers the bridge strobe to the timer or GPIO region, passes the low
// register offset to both and merges their acks and read data back.
// Unmapped addresses get a registered error ack carrying UNMAPPED_DATA.

`timescale 1ns/100ps

module periph_decode (
   input  logic                  clk,
   input  logic                  i_arst_n,
   input  logic                  i_bus_stb,
   input  io_bus_pkg::addr_t     i_bus_addr,
   output logic                  o_sys_stb,
   output logic                  o_gpio_stb,
   output periph_pkg::reg_ofs_t  o_ofs,
   input  logic                  i_sys_ack,
   input  io_bus_pkg::data_t     i_sys_rdata,
   input  logic                  i_gpio_ack,
   input  io_bus_pkg::data_t     i_gpio_rdata,
   output logic                  o_bus_ack,
   output logic                  o_bus_err,
   output io_bus_pkg::data_t     o_bus_rdata
);

   io_bus_pkg::addr_t region;

   logic sys_hit;
   logic gpio_hit;
   logic err_ack;

   assign region   = i_bus_addr & io_bus_pkg::REGION_MASK;
   assign sys_hit  = (region == io_bus_pkg::SYS_BASE);
   assign gpio_hit = (region == io_bus_pkg::GPIO_BASE);

   assign o_sys_stb  = i_bus_stb & sys_hit;
   assign o_gpio_stb = i_bus_stb & gpio_hit;
   assign o_ofs      = i_bus_addr[periph_pkg::REG_OFS_W-1:0];

   // Stand-in slave for addresses outside both regions
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         err_ack <= 1'b0;
      end else begin
         err_ack <= i_bus_stb & ~sys_hit & ~gpio_hit;
      end
   end

   assign o_bus_ack = i_sys_ack | i_gpio_ack | err_ack;
   assign o_bus_err = err_ack;

   // Only one source can ack in a given cycle
   always_comb begin
      if (err_ack) begin
         o_bus_rdata = io_bus_pkg::UNMAPPED_DATA;
      end else if (i_sys_ack) begin
         o_bus_rdata = i_sys_rdata;
      end else if (i_gpio_ack) begin
         o_bus_rdata = i_gpio_rdata;
      end else begin
         o_bus_rdata = '0;
      end
   end

endmodule

//--- verilog/sys_timer.sv
// System timer with compare interrupt.
// A 32-bit count runs while CTRL bit 0 is set. o_timer_irq is raised,
// one edge late, whenever the count is at or above the compare value.
// Registers are written with byte strobes and every strobe is acked
// one cycle later.

`timescale 1ns/100ps

module sys_timer (
   input  logic                  clk,
   input  logic                  i_arst_n,
   input  logic                  i_stb,
   input  logic                  i_we,
   input  periph_pkg::reg_ofs_t  i_ofs,
   input  io_bus_pkg::data_t     i_wdata,
   input  io_bus_pkg::strb_t     i_strb,
   output logic                  o_ack,
   output io_bus_pkg::data_t     o_rdata,
   output logic                  o_timer_irq
);

   logic              tmr_en;
   periph_pkg::tmr_t  count;
   periph_pkg::tmr_t  cmp;
   io_bus_pkg::data_t wmask;

   logic wr;

   assign wr    = i_stb & i_we;
   assign wmask = {{8{i_strb[3]}}, {8{i_strb[2]}}, {8{i_strb[1]}}, {8{i_strb[0]}}};

   // ****************************************
   // Registers and counter
   // ****************************************

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         tmr_en      <= 1'b0;
         count       <= '0;
         cmp         <= '1;
         o_timer_irq <= 1'b0;
         o_ack       <= 1'b0;
      end else begin
         o_ack       <= i_stb;
         o_timer_irq <= (count >= cmp);

         if (wr && i_ofs == periph_pkg::TMR_CTRL && i_strb[0]) begin
            tmr_en <= i_wdata[0];
         end

         // Bus write wins over the increment
         if (wr && i_ofs == periph_pkg::TMR_COUNT) begin
            count <= (count & ~wmask) | (i_wdata & wmask);
         end else if (tmr_en) begin
            count <= count + 1'b1;
         end

         if (wr && i_ofs == periph_pkg::TMR_CMP) begin
            cmp <= (cmp & ~wmask) | (i_wdata & wmask);
         end
      end
   end

   // Offsets not in the map read back as zero
   always_ff @(posedge clk) begin
      if (i_stb) begin
         case (i_ofs)
            periph_pkg::TMR_CTRL:  o_rdata <= {31'd0, tmr_en};
            periph_pkg::TMR_COUNT: o_rdata <= count;
            periph_pkg::TMR_CMP:   o_rdata <= cmp;
            default:               o_rdata <= '0;
         endcase
      end
   end

endmodule

//--- verilog/gpio_regs.sv
// GPIO register block.
// OUT and OE drive the output and output-enable pins directly. Input pins
// go through a two-flop synchroniser and are read back at GPIO_IN.
// Writes use byte strobes; each strobe is acked one cycle later.

`timescale 1ns/100ps

module gpio_regs (
   input  logic                  clk,
   input  logic                  i_arst_n,
   input  logic                  i_stb,
   input  logic                  i_we,
   input  periph_pkg::reg_ofs_t  i_ofs,
   input  io_bus_pkg::data_t     i_wdata,
   input  io_bus_pkg::strb_t     i_strb,
   output logic                  o_ack,
   output io_bus_pkg::data_t     o_rdata,
   input  periph_pkg::gpio_t     i_gpio_in,
   output periph_pkg::gpio_t     o_gpio_out,
   output periph_pkg::gpio_t     o_gpio_oe
);

   periph_pkg::gpio_t in_meta;
   periph_pkg::gpio_t in_sync;
   io_bus_pkg::data_t wmask;

   logic wr;

   assign wr    = i_stb & i_we;
   assign wmask = {{8{i_strb[3]}}, {8{i_strb[2]}}, {8{i_strb[1]}}, {8{i_strb[0]}}};

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_gpio_out <= '0;
         o_gpio_oe  <= '0;
         in_meta    <= '0;
         in_sync    <= '0;
         o_ack      <= 1'b0;
      end else begin
         o_ack   <= i_stb;
         // Pin change visible at GPIO_IN two edges later
         in_meta <= i_gpio_in;
         in_sync <= in_meta;
         if (wr && i_ofs == periph_pkg::GPIO_OUT) begin
            o_gpio_out <= (o_gpio_out & ~wmask) | (i_wdata & wmask);
         end
         if (wr && i_ofs == periph_pkg::GPIO_OE) begin
            o_gpio_oe <= (o_gpio_oe & ~wmask) | (i_wdata & wmask);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_stb) begin
         case (i_ofs)
            periph_pkg::GPIO_OUT: o_rdata <= o_gpio_out;
            periph_pkg::GPIO_OE:  o_rdata <= o_gpio_oe;
            periph_pkg::GPIO_IN:  o_rdata <= in_sync;
            default:              o_rdata <= '0;
         endcase
      end
   end

endmodule

//--- verilog/io_subsys_top.sv
// Peripheral I/O subsystem top level.
// Request and response channels enter the bridge, which drives the
// internal register bus through the decoder to the timer and GPIO blocks.
// GPIO pins are split into input, output and output-enable vectors.

`timescale 1ns/100ps

module io_subsys_top (
   input  logic               clk,
   input  logic               i_arst_n,
   input  logic               i_req_valid,
   input  logic               i_req_we,
   input  io_bus_pkg::addr_t  i_req_addr,
   input  io_bus_pkg::data_t  i_req_wdata,
   input  io_bus_pkg::strb_t  i_req_strb,
   output logic               o_req_ready,
   output logic               o_rsp_valid,
   output io_bus_pkg::data_t  o_rsp_rdata,
   output logic               o_rsp_err,
   input  logic               i_rsp_ready,
   output logic               o_timer_irq,
   input  periph_pkg::gpio_t  i_gpio_in,
   output periph_pkg::gpio_t  o_gpio_out,
   output periph_pkg::gpio_t  o_gpio_oe
);

   // Bridge side of the register bus
   logic                  bus_stb;
   logic                  bus_we;
   io_bus_pkg::addr_t     bus_addr;
   io_bus_pkg::data_t     bus_wdata;
   io_bus_pkg::strb_t     bus_strb;
   logic                  bus_ack;
   logic                  bus_err;
   io_bus_pkg::data_t     bus_rdata;

   // Decoded slave side
   logic                  sys_stb;
   logic                  sys_ack;
   io_bus_pkg::data_t     sys_rdata;
   logic                  gpio_stb;
   logic                  gpio_ack;
   io_bus_pkg::data_t     gpio_rdata;
   periph_pkg::reg_ofs_t  ofs;

   bus_bridge_fsm bridge0 (
      .clk (clk), .i_arst_n (i_arst_n),
      .i_req_valid (i_req_valid), .i_req_we (i_req_we), .i_req_addr (i_req_addr),
      .i_req_wdata (i_req_wdata), .i_req_strb (i_req_strb), .o_req_ready (o_req_ready),
      .o_rsp_valid (o_rsp_valid), .o_rsp_rdata (o_rsp_rdata), .o_rsp_err (o_rsp_err),
      .i_rsp_ready (i_rsp_ready),
      .o_bus_stb (bus_stb), .o_bus_we (bus_we), .o_bus_addr (bus_addr),
      .o_bus_wdata (bus_wdata), .o_bus_strb (bus_strb),
      .i_bus_ack (bus_ack), .i_bus_err (bus_err), .i_bus_rdata (bus_rdata)
   );

   periph_decode decode0 (
      .clk (clk), .i_arst_n (i_arst_n),
      .i_bus_stb (bus_stb), .i_bus_addr (bus_addr),
      .o_sys_stb (sys_stb), .o_gpio_stb (gpio_stb), .o_ofs (ofs),
      .i_sys_ack (sys_ack), .i_sys_rdata (sys_rdata),
      .i_gpio_ack (gpio_ack), .i_gpio_rdata (gpio_rdata),
      .o_bus_ack (bus_ack), .o_bus_err (bus_err), .o_bus_rdata (bus_rdata)
   );

   sys_timer timer0 (
      .clk (clk), .i_arst_n (i_arst_n),
      .i_stb (sys_stb), .i_we (bus_we), .i_ofs (ofs),
      .i_wdata (bus_wdata), .i_strb (bus_strb),
      .o_ack (sys_ack), .o_rdata (sys_rdata), .o_timer_irq (o_timer_irq)
   );

   gpio_regs gpio0 (
      .clk (clk), .i_arst_n (i_arst_n),
      .i_stb (gpio_stb), .i_we (bus_we), .i_ofs (ofs),
      .i_wdata (bus_wdata), .i_strb (bus_strb),
      .o_ack (gpio_ack), .o_rdata (gpio_rdata),
      .i_gpio_in (i_gpio_in), .o_gpio_out (o_gpio_out), .o_gpio_oe (o_gpio_oe)
   );

endmodule

//--- testbench/io_checker.sv
// Response checker for the I/O subsystem testbench.
// Records each accepted request with the expected response that the
// testbench drives next to it. Keeps a model of the GPIO pins and the
// timer compare value, and checks every response handshake in order.
// Also counts cycles and raises o_timeout at the given limit.

`timescale 1ns/100ps

module io_checker (
   input  logic               clk,
   input  logic               i_arst_n,
   input  logic               i_req_valid,
   input  logic               i_req_ready,
   input  logic               i_req_we,
   input  io_bus_pkg::addr_t  i_req_addr,
   input  io_bus_pkg::data_t  i_req_wdata,
   input  io_bus_pkg::strb_t  i_req_strb,
   input  io_bus_pkg::data_t  i_exp_rdata,
   input  logic               i_exp_err,
   input  logic               i_exp_gt,
   input  logic               i_rsp_valid,
   input  logic               i_rsp_ready,
   input  io_bus_pkg::data_t  i_rsp_rdata,
   input  logic               i_rsp_err,
   input  logic               i_timer_irq,
   input  periph_pkg::gpio_t  i_gpio_out,
   input  periph_pkg::gpio_t  i_gpio_oe,
   input  int                 i_cycle_limit,
   output int                 o_mismatches,
   output int                 o_other_errs,
   output int                 o_pending,
   output logic               o_timeout
);

   io_bus_pkg::data_t exp_rdata_q[$];
   logic              exp_err_q[$];
   logic              exp_gt_q[$];

   periph_pkg::gpio_t model_out;
   periph_pkg::gpio_t model_oe;
   periph_pkg::tmr_t  model_cmp;
   io_bus_pkg::data_t last_count;
   int                cycles;

   initial begin
      o_mismatches = 0;
      o_other_errs = 0;
      o_pending    = 0;
      o_timeout    = 1'b0;
      cycles       = 0;
      last_count   = '0;
      model_out    = '0;
      model_oe     = '0;
      model_cmp    = '1;
   end

   function automatic io_bus_pkg::data_t merge_bytes(input io_bus_pkg::data_t old_val,
                                                     input io_bus_pkg::data_t new_val,
                                                     input io_bus_pkg::strb_t strb);
      io_bus_pkg::data_t res;
      res = old_val;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            res[8*b +: 8] = new_val[8*b +: 8];
         end
      end
      return res;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
      o_mismatches++;
   endtask

   // ****************************************
   // Request side queue and pin model
   // ****************************************

   task automatic record_request();
      periph_pkg::reg_ofs_t ofs;
      io_bus_pkg::addr_t    region;
      ofs    = i_req_addr[periph_pkg::REG_OFS_W-1:0];
      region = i_req_addr & io_bus_pkg::REGION_MASK;
      exp_rdata_q.push_back(i_exp_rdata);
      exp_err_q.push_back(i_exp_err);
      exp_gt_q.push_back(i_exp_gt);
      if (i_req_we && region == io_bus_pkg::GPIO_BASE) begin
         if (ofs == periph_pkg::GPIO_OUT) begin
            model_out = merge_bytes(model_out, i_req_wdata, i_req_strb);
         end
         if (ofs == periph_pkg::GPIO_OE) begin
            model_oe = merge_bytes(model_oe, i_req_wdata, i_req_strb);
         end
      end
      if (i_req_we && region == io_bus_pkg::SYS_BASE && ofs == periph_pkg::TMR_CMP) begin
         model_cmp = merge_bytes(model_cmp, i_req_wdata, i_req_strb);
      end
   endtask

   // ****************************************
   // Response side
   // ****************************************

   task automatic check_response();
      io_bus_pkg::data_t exp_rdata;
      io_bus_pkg::data_t floor;
      logic              exp_err;
      logic              exp_gt;
      if (exp_rdata_q.size() == 0) begin
         $display("Response at %0t arrived with no request outstanding", $time);
         o_other_errs++;
         return;
      end
      exp_rdata = exp_rdata_q.pop_front();
      exp_err   = exp_err_q.pop_front();
      exp_gt    = exp_gt_q.pop_front();
      if (exp_gt) begin
         // Only the direction of a running counter is known
         floor = (last_count > exp_rdata) ? last_count : exp_rdata;
         if (i_rsp_rdata <= floor) begin
            $display("MISMATCH o_rsp_rdata: got %h, expected above %h", i_rsp_rdata, floor);
            o_mismatches++;
         end
         last_count = i_rsp_rdata;
      end else if (i_rsp_rdata !== exp_rdata) begin
         report_mismatch("o_rsp_rdata", i_rsp_rdata, exp_rdata);
      end
      if (i_rsp_err !== exp_err) begin
         report_mismatch("o_rsp_err", 32'(i_rsp_err), 32'(exp_err));
      end
      if (i_gpio_out !== model_out) begin
         report_mismatch("o_gpio_out", i_gpio_out, model_out);
      end
      if (i_gpio_oe !== model_oe) begin
         report_mismatch("o_gpio_oe", i_gpio_oe, model_oe);
      end
      // Irq is only certain at the two ends of the compare range
      if (model_cmp == '1 && i_timer_irq !== 1'b0) begin
         report_mismatch("o_timer_irq", 32'(i_timer_irq), 32'd0);
      end else if (model_cmp == '0 && i_timer_irq !== 1'b1) begin
         report_mismatch("o_timer_irq", 32'(i_timer_irq), 32'd1);
      end
   endtask

   always @(posedge clk) begin
      cycles++;
      if (cycles >= i_cycle_limit && !o_timeout) begin
         $display("Run did not finish within %0d cycles, %0d responses outstanding",
                  i_cycle_limit, o_pending);
         o_other_errs++;
         o_timeout = 1'b1;
      end
      if (i_arst_n) begin
         if (i_rsp_valid && i_req_ready) begin
            $display("Request channel ready at %0t while a response is waiting", $time);
            o_other_errs++;
         end
         if (i_rsp_valid && i_rsp_ready) begin
            check_response();
         end
         if (i_req_valid && i_req_ready) begin
            record_request();
         end
         o_pending = exp_rdata_q.size();
      end
   end

endmodule

//--- testbench/tb_io_subsys.sv
// Testbench top for the peripheral I/O subsystem.
// Applies a table of register accesses through the request channel while
// an LFSR throttles the response channel. io_checker compares each
// response and the pins; this module reports the overall result.

`timescale 1ns/100ps

module tb_io_subsys;

   localparam int RESET_CYCLES     = 2;
   localparam int CYCLES_PER_ENTRY = 20;

   logic              clk       = 1'b0;
   logic              arst_n    = 1'b0;
   logic              req_valid = 1'b0;
   logic              req_we    = 1'b0;
   io_bus_pkg::addr_t req_addr  = '0;
   io_bus_pkg::data_t req_wdata = '0;
   io_bus_pkg::strb_t req_strb  = '0;
   logic              rsp_ready = 1'b0;
   periph_pkg::gpio_t gpio_in   = '0;
   io_bus_pkg::data_t exp_rdata = '0;
   logic              exp_err   = 1'b0;
   logic              exp_gt    = 1'b0;
   logic [31:0]       lfsr      = 32'd72668;
   int                cycle_limit = 0;

   logic              req_ready;
   logic              rsp_valid;
   io_bus_pkg::data_t rsp_rdata;
   logic              rsp_err;
   logic              timer_irq;
   periph_pkg::gpio_t gpio_out;
   periph_pkg::gpio_t gpio_oe;
   int                mismatches;
   int                other_errs;
   int                pending;
   logic              timed_out;

   // Stimulus table with one access per row
   logic              tbl_we[$];
   io_bus_pkg::addr_t tbl_addr[$];
   io_bus_pkg::data_t tbl_wdata[$];
   io_bus_pkg::strb_t tbl_strb[$];
   periph_pkg::gpio_t tbl_gpio_in[$];
   io_bus_pkg::data_t tbl_rdata[$];
   logic              tbl_err[$];
   logic              tbl_gt[$];

   always #4 clk = ~clk;

   io_subsys_top dut0 (
      .clk (clk), .i_arst_n (arst_n),
      .i_req_valid (req_valid), .i_req_we (req_we), .i_req_addr (req_addr),
      .i_req_wdata (req_wdata), .i_req_strb (req_strb), .o_req_ready (req_ready),
      .o_rsp_valid (rsp_valid), .o_rsp_rdata (rsp_rdata), .o_rsp_err (rsp_err),
      .i_rsp_ready (rsp_ready), .o_timer_irq (timer_irq),
      .i_gpio_in (gpio_in), .o_gpio_out (gpio_out), .o_gpio_oe (gpio_oe)
   );

   io_checker chk0 (
      .clk (clk), .i_arst_n (arst_n),
      .i_req_valid (req_valid), .i_req_ready (req_ready), .i_req_we (req_we),
      .i_req_addr (req_addr), .i_req_wdata (req_wdata), .i_req_strb (req_strb),
      .i_exp_rdata (exp_rdata), .i_exp_err (exp_err), .i_exp_gt (exp_gt),
      .i_rsp_valid (rsp_valid), .i_rsp_ready (rsp_ready), .i_rsp_rdata (rsp_rdata),
      .i_rsp_err (rsp_err), .i_timer_irq (timer_irq),
      .i_gpio_out (gpio_out), .i_gpio_oe (gpio_oe), .i_cycle_limit (cycle_limit),
      .o_mismatches (mismatches), .o_other_errs (other_errs),
      .o_pending (pending), .o_timeout (timed_out)
   );

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] state);
      logic fb;
      fb = state[31] ^ state[21] ^ state[1] ^ state[0];
      return {state[30:0], fb};
   endfunction

   // One new bit per cycle for response back-pressure
   always @(negedge clk) begin
      lfsr      = lfsr_step(lfsr);
      rsp_ready = lfsr[0];
   end

   task automatic add_entry(input logic we, input io_bus_pkg::addr_t addr,
                            input io_bus_pkg::data_t wdata, input io_bus_pkg::strb_t strb,
                            input periph_pkg::gpio_t gin, input io_bus_pkg::data_t rdata,
                            input logic err, input logic gt);
      tbl_we.push_back(we);
      tbl_addr.push_back(addr);
      tbl_wdata.push_back(wdata);
      tbl_strb.push_back(strb);
      tbl_gpio_in.push_back(gin);
      tbl_rdata.push_back(rdata);
      tbl_err.push_back(err);
      tbl_gt.push_back(gt);
   endtask

   // ****************************************
   // Table columns we addr wdata strb gpio_in rdata err gt
   // ****************************************

   task automatic load_table();
      add_entry(1'b1, 16'h0100, 32'hA5A5_1234, 4'hF, 32'h0, 32'h0, 1'b0, 1'b0);
      add_entry(1'b1, 16'h0104, 32'h0000_FFFF, 4'hF, 32'h0, 32'h0, 1'b0, 1'b0);
      add_entry(1'b0, 16'h0100, 32'h0, 4'h0, 32'h0, 32'hA5A5_1234, 1'b0, 1'b0);
      add_entry(1'b0, 16'h0104, 32'h0, 4'h0, 32'h0, 32'h0000_FFFF, 1'b0, 1'b0);
      // Partial strobes
      add_entry(1'b1, 16'h0100, 32'h5A5A_CDEF, 4'h5, 32'h0, 32'h0, 1'b0, 1'b0);
      add_entry(1'b0, 16'h0100, 32'h0, 4'h0, 32'h0, 32'hA55A_12EF, 1'b0, 1'b0);
      add_entry(1'b1, 16'h0104, 32'hFF00_0000, 4'h8, 32'h0, 32'h0, 1'b0, 1'b0);
      add_entry(1'b0, 16'h0104, 32'h0, 4'h0, 32'h0, 32'hFF00_FFFF, 1'b0, 1'b0);
      add_entry(1'b0, 16'h0108, 32'h0, 4'h0, 32'hC0DE_F00D, 32'hC0DE_F00D, 1'b0, 1'b0);
      add_entry(1'b0, 16'h0108, 32'h0, 4'h0, 32'h1357_9BDF, 32'h1357_9BDF, 1'b0, 1'b0);
      // Unmapped and undefined
      add_entry(1'b0, 16'h0200, 32'h0, 4'h0, 32'h0, 32'hDEAD_BEEF, 1'b1, 1'b0);
      add_entry(1'b1, 16'hFF10, 32'h1, 4'hF, 32'h0, 32'h0, 1'b1, 1'b0);
      add_entry(1'b0, 16'h010C, 32'h0, 4'h0, 32'h0, 32'h0, 1'b0, 1'b0);
      // Timer
      add_entry(1'b0, 16'h0008, 32'h0, 4'h0, 32'h0, 32'hFFFF_FFFF, 1'b0, 1'b0);
      add_entry(1'b1, 16'h0004, 32'h0000_1000, 4'hF, 32'h0, 32'h0, 1'b0, 1'b0);
      add_entry(1'b0, 16'h0004, 32'h0, 4'h0, 32'h0, 32'h0000_1000, 1'b0, 1'b0);
      add_entry(1'b1, 16'h0000, 32'h1, 4'hF, 32'h0, 32'h0, 1'b0, 1'b0);
      add_entry(1'b0, 16'h0004, 32'h0, 4'h0, 32'h0, 32'h0000_1000, 1'b0, 1'b1);
      add_entry(1'b0, 16'h0004, 32'h0, 4'h0, 32'h0, 32'h0000_1000, 1'b0, 1'b1);
      add_entry(1'b1, 16'h0008, 32'h0, 4'hF, 32'h0, 32'h0, 1'b0, 1'b0);
      add_entry(1'b0, 16'h0008, 32'h0, 4'h0, 32'h0, 32'h0, 1'b0, 1'b0);
      add_entry(1'b0, 16'h0100, 32'h0, 4'h0, 32'h0, 32'hA55A_12EF, 1'b0, 1'b0);
   endtask

   task automatic apply_entry(input int idx);
      @(negedge clk);
      gpio_in = tbl_gpio_in[idx];
      // Two edges for the input synchroniser
      repeat (2) @(negedge clk);
      req_valid = 1'b1;
      req_we    = tbl_we[idx];
      req_addr  = tbl_addr[idx];
      req_wdata = tbl_wdata[idx];
      req_strb  = tbl_strb[idx];
      exp_rdata = tbl_rdata[idx];
      exp_err   = tbl_err[idx];
      exp_gt    = tbl_gt[idx];
      while (!req_ready) @(negedge clk);
      @(negedge clk);
      req_valid = 1'b0;
   endtask

   task automatic print_error_counts();
      $display("Error counts: %0d mismatches, %0d other errors", mismatches, other_errs);
   endtask

   initial begin
      load_table();
      cycle_limit = tbl_addr.size() * CYCLES_PER_ENTRY + RESET_CYCLES;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      for (int i = 0; i < tbl_addr.size(); i++) begin
         apply_entry(i);
      end
      while (pending != 0 || rsp_valid) @(negedge clk);
      print_error_counts();
      if (mismatches == 0 && other_errs == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   initial begin
      wait (timed_out === 1'b1);
      print_error_counts();
      $display("Some tests failed");
      $finish;
   end

endmodule

//--- io_subsys.f
verilog/io_bus_pkg.sv
verilog/periph_pkg.sv
verilog/bus_bridge_fsm.sv
verilog/periph_decode.sv
verilog/sys_timer.sv
verilog/gpio_regs.sv
verilog/io_subsys_top.sv
testbench/io_checker.sv
testbench/tb_io_subsys.sv

//--- Makefile
# Verilator build and run for the peripheral I/O subsystem

VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal -j 0
TOP       := tb_io_subsys
FILELIST  := io_subsys.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "Result: FAIL"; exit 1; fi
	@grep -q "All tests passed" $(LOG) || (echo "Result: FAIL"; exit 1)
	@echo "Result: PASS"

clean:
	rm -rf $(OBJDIR) $(LOG)
